// ==== audio_dsp_pkg.sv ====
package audio_dsp_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths

	// one audio sample, two's complement
	localparam int unsigned sample_width = 16;
	// filter word, 2.16 signed
	localparam int unsigned coeff_width = 18;
	// fraction bits of a filter word
	localparam int unsigned coeff_frac = 16;
	// bus address and data
	localparam int unsigned bus_width = 32;
	// fifo space counts in the status word
	localparam int unsigned space_width = 8;

	//////////////////////////////////////////////////////////////////////
	// codec register map

	localparam logic [bus_width-1:0] fifo_status_addr = 32'h0000_3044;
	localparam logic [bus_width-1:0] left_data_addr = 32'h0000_3048;
	localparam logic [bus_width-1:0] right_data_addr = 32'h0000_304c;

	// write only with more free words than this
	localparam logic [space_width-1:0] write_space_min = 8'd2;

	// 48 kHz down to 8 kHz
	localparam int unsigned decimation_ratio = 6;
	localparam int unsigned dec_count_width = $clog2(decimation_ratio);

	//////////////////////////////////////////////////////////////////////
	// coefficient sets, order b1 b2 b3 a2 a3

	// 300 Hz band-pass at 48 kHz
	localparam logic signed [coeff_width-1:0] bp300_48k_b1 = 18'sd426;
	localparam logic signed [coeff_width-1:0] bp300_48k_b2 = 18'sd0;
	localparam logic signed [coeff_width-1:0] bp300_48k_b3 = -18'sd426;
	localparam logic signed [coeff_width-1:0] bp300_48k_a2 = 18'sd130122;
	localparam logic signed [coeff_width-1:0] bp300_48k_a3 = -18'sd64683;

	// first decimation low-pass, about 4 kHz
	localparam logic signed [coeff_width-1:0] dec_lp1_b1 = 18'sd885;
	localparam logic signed [coeff_width-1:0] dec_lp1_b2 = 18'sd1771;
	localparam logic signed [coeff_width-1:0] dec_lp1_b3 = 18'sd885;
	localparam logic signed [coeff_width-1:0] dec_lp1_a2 = 18'sd112357;
	localparam logic signed [coeff_width-1:0] dec_lp1_a3 = -18'sd56805;

	// second decimation low-pass, about 2 kHz
	localparam logic signed [coeff_width-1:0] dec_lp2_b1 = 18'sd943;
	localparam logic signed [coeff_width-1:0] dec_lp2_b2 = 18'sd1887;
	localparam logic signed [coeff_width-1:0] dec_lp2_b3 = 18'sd943;
	localparam logic signed [coeff_width-1:0] dec_lp2_a2 = 18'sd107019;
	localparam logic signed [coeff_width-1:0] dec_lp2_a3 = -18'sd45259;

	// 300 Hz band-pass at the 8 kHz rate
	localparam logic signed [coeff_width-1:0] bp300_8k_b1 = 18'sd2477;
	localparam logic signed [coeff_width-1:0] bp300_8k_b2 = 18'sd0;
	localparam logic signed [coeff_width-1:0] bp300_8k_b3 = -18'sd2477;
	localparam logic signed [coeff_width-1:0] bp300_8k_a2 = 18'sd122726;
	localparam logic signed [coeff_width-1:0] bp300_8k_a3 = -18'sd60580;

	//////////////////////////////////////////////////////////////////////
	// state encodings

	typedef enum logic [3:0] {
		status_rd, wr_left, wr_right, rd_left, rd_right, strobe, settle
	} bus_state_t;

	typedef enum logic [2:0] {
		idle, b1_step, b2_step, b3_step, a2_step, a3_step, update
	} biquad_step_t;

endpackage

// ==== biquad_filter.sv ====
`timescale 1ns/1ps

module biquad_filter
	import audio_dsp_pkg::*;
#(
	parameter logic signed [coeff_width-1:0] b1 = 18'sd0,
	parameter logic signed [coeff_width-1:0] b2 = 18'sd0,
	parameter logic signed [coeff_width-1:0] b3 = 18'sd0,
	parameter logic signed [coeff_width-1:0] a2 = 18'sd0,
	parameter logic signed [coeff_width-1:0] a3 = 18'sd0
) (
	input  logic                           CLOCK_50,
	input  logic                           reset,
	input  logic                           sample_ready,
	input  logic signed [sample_width-1:0] audio_in,
	output logic signed [sample_width-1:0] audio_out
);

	// y(n) = b1 x(n) + b2 x(n-1) + b3 x(n-2) + a2 y(n-1) + a3 y(n-2)
	// a2 and a3 already carry the sign flip
	biquad_step_t step;

	// input sign extended to a filter word
	logic signed [coeff_width-1:0] x_ext;
	logic signed [coeff_width-1:0] x_n, x_n1, x_n2;
	logic signed [coeff_width-1:0] y_n1, y_n2;

	// one multiplier and one accumulator
	logic signed [coeff_width-1:0] coeff, value;
	logic signed [coeff_width-1:0] mac_old, mac_new;
	logic signed [2*coeff_width-1:0] product;

	assign x_ext = {{(coeff_width-sample_width){audio_in[sample_width-1]}}, audio_in};

	//////////////////////////////////////////////////////////////////////
	// 2.16 multiply and accumulate

	assign product = coeff * value;
	// keep the sign and drop the two integer guard bits and the low fraction
	assign mac_new = mac_old + {product[2*coeff_width-1],
		product[coeff_frac+coeff_width-2:coeff_frac]};

	//////////////////////////////////////////////////////////////////////
	// step sequencer with one coefficient per cycle

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			step <= idle;
			x_n <= '0;
			x_n1 <= '0;
			x_n2 <= '0;
			y_n1 <= '0;
			y_n2 <= '0;
			// idle accumulator reads as zero
			mac_old <= '0;
			coeff <= '0;
			value <= '0;
		end else begin
			case (step)
				idle: begin
					if (sample_ready) begin
						step <= b1_step;
					end
				end
				b1_step: begin
					// fresh sum starts with b1 * x(n)
					mac_old <= '0;
					coeff <= b1;
					value <= x_ext;
					x_n <= x_ext;
					step <= b2_step;
				end
				b2_step: begin
					mac_old <= mac_new;
					coeff <= b2;
					value <= x_n1;
					step <= b3_step;
				end
				b3_step: begin
					mac_old <= mac_new;
					coeff <= b3;
					value <= x_n2;
					step <= a2_step;
				end
				a2_step: begin
					mac_old <= mac_new;
					coeff <= a2;
					value <= y_n1;
					step <= a3_step;
				end
				a3_step: begin
					mac_old <= mac_new;
					coeff <= a3;
					value <= y_n2;
					step <= update;
				end
				update: begin
					// mac_new now holds the full sum and stays there until the next strobe
					y_n1 <= mac_new;
					y_n2 <= y_n1;
					x_n1 <= x_n;
					x_n2 <= x_n1;
					step <= idle;
				end
				default: begin
					step <= idle;
				end
			endcase
		end
	end

	// result of the previous sample goes out on the strobe
	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			audio_out <= '0;
		end else if (step == idle && sample_ready) begin
			audio_out <= mac_new[sample_width-1:0];
		end
	end

endmodule

// ==== decimation_chain.sv ====
`timescale 1ns/1ps

module decimation_chain
	import audio_dsp_pkg::*;
(
	input  logic                           CLOCK_50,
	input  logic                           reset,
	input  logic                           sample_ready,
	input  logic signed [sample_width-1:0] audio_in,
	output logic signed [sample_width-1:0] audio_out
);

	// low-pass outputs at 48 kHz
	logic signed [sample_width-1:0] stage1_out, stage2_out;
	// band-pass input, gain of two
	logic signed [sample_width-1:0] stage3_in;

	// 8 kHz strobe
	logic dec_ready;
	logic [dec_count_width-1:0] sample_count;

	//////////////////////////////////////////////////////////////////////
	// 6:1 sample counter

	assign dec_ready = sample_ready && (sample_count == dec_count_width'(decimation_ratio - 1));

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			sample_count <= '0;
		end else if (dec_ready) begin
			sample_count <= '0;
		end else if (sample_ready) begin
			sample_count <= sample_count + 1'b1;
		end
	end

	// decimator loses about one bit of level
	assign stage3_in = {stage2_out[sample_width-2:0], 1'b0};

	//////////////////////////////////////////////////////////////////////
	// filter stages

	biquad_filter #(
		.b1(dec_lp1_b1), .b2(dec_lp1_b2), .b3(dec_lp1_b3), .a2(dec_lp1_a2), .a3(dec_lp1_a3)
	) lp1_i (
		.CLOCK_50(CLOCK_50), .reset(reset), .sample_ready(sample_ready),
		.audio_in(audio_in), .audio_out(stage1_out)
	);

	biquad_filter #(
		.b1(dec_lp2_b1), .b2(dec_lp2_b2), .b3(dec_lp2_b3), .a2(dec_lp2_a2), .a3(dec_lp2_a3)
	) lp2_i (
		.CLOCK_50(CLOCK_50), .reset(reset), .sample_ready(sample_ready),
		.audio_in(stage1_out), .audio_out(stage2_out)
	);

	// only every sixth sample reaches the band-pass
	biquad_filter #(
		.b1(bp300_8k_b1), .b2(bp300_8k_b2), .b3(bp300_8k_b3), .a2(bp300_8k_a2), .a3(bp300_8k_a3)
	) bp_i (
		.CLOCK_50(CLOCK_50), .reset(reset), .sample_ready(dec_ready),
		.audio_in(stage3_in), .audio_out(audio_out)
	);

endmodule

// ==== audio_bus_master.sv ====
`timescale 1ns/1ps

module audio_bus_master
	import audio_dsp_pkg::*;
(
	input  logic                           CLOCK_50,
	input  logic                           reset,
	input  logic                           left_filter_en,
	input  logic                           right_filter_en,
	input  logic signed [sample_width-1:0] left_filtered,
	input  logic signed [sample_width-1:0] right_filtered,
	input  logic                           bus_ack,
	input  logic [bus_width-1:0]           bus_read_data,
	output logic [bus_width-1:0]           bus_addr,
	output logic [bus_width-1:0]           bus_write_data,
	output logic                           bus_read,
	output logic                           bus_write,
	output logic                           sample_ready,
	output logic signed [sample_width-1:0] left_in,
	output logic signed [sample_width-1:0] right_in
);

	bus_state_t state;

	// output pair waiting for fifo space
	logic pending;
	logic signed [sample_width-1:0] left_out, right_out;

	// status word fields, write space high byte, read count low byte
	logic [space_width-1:0] write_space;
	logic [space_width-1:0] fifo_count;
	// read count kept for after the writes
	logic [space_width-1:0] read_count;

	assign write_space = bus_read_data[bus_width-1 -: space_width];
	assign fifo_count = bus_read_data[space_width-1:0];

	// one cycle, the cycle after the right read ack
	assign sample_ready = (state == strobe);

	//////////////////////////////////////////////////////////////////////
	// bus sequencer
	// request rises one cycle into a state, drops on the edge after ack

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			state <= status_rd;
			bus_read <= 1'b0;
			bus_write <= 1'b0;
			pending <= 1'b0;
		end else begin
			case (state)
				status_rd: begin
					if (!bus_read) begin
						bus_read <= 1'b1;
					end else if (bus_ack) begin
						bus_read <= 1'b0;
						// writes first, then reads
						if (pending && write_space > write_space_min) begin
							state <= wr_left;
						end else if (fifo_count != '0) begin
							state <= rd_left;
						end else begin
							state <= status_rd;
						end
					end
				end
				wr_left: begin
					if (!bus_write) begin
						bus_write <= 1'b1;
					end else if (bus_ack) begin
						bus_write <= 1'b0;
						state <= wr_right;
					end
				end
				wr_right: begin
					if (!bus_write) begin
						bus_write <= 1'b1;
					end else if (bus_ack) begin
						bus_write <= 1'b0;
						pending <= 1'b0;
						state <= (read_count != '0) ? rd_left : status_rd;
					end
				end
				rd_left: begin
					if (!bus_read) begin
						bus_read <= 1'b1;
					end else if (bus_ack) begin
						bus_read <= 1'b0;
						state <= rd_right;
					end
				end
				rd_right: begin
					if (!bus_read) begin
						bus_read <= 1'b1;
					end else if (bus_ack) begin
						bus_read <= 1'b0;
						state <= strobe;
					end
				end
				strobe: begin
					pending <= 1'b1;
					state <= settle;
				end
				settle: begin
					// filters start their sums here
					state <= status_rd;
				end
				default: begin
					state <= status_rd;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// address, data and sample registers

	always_ff @(posedge CLOCK_50) begin
		case (state)
			status_rd: begin
				bus_addr <= fifo_status_addr;
				if (bus_read && bus_ack) begin
					read_count <= fifo_count;
				end
			end
			wr_left: begin
				bus_addr <= left_data_addr;
				// sample in the low half, upper half zero
				bus_write_data <= {{(bus_width-sample_width){1'b0}}, left_out};
			end
			wr_right: begin
				bus_addr <= right_data_addr;
				bus_write_data <= {{(bus_width-sample_width){1'b0}}, right_out};
			end
			rd_left: begin
				bus_addr <= left_data_addr;
				if (bus_read && bus_ack) begin
					left_in <= bus_read_data[sample_width-1:0];
				end
			end
			rd_right: begin
				bus_addr <= right_data_addr;
				if (bus_read && bus_ack) begin
					right_in <= bus_read_data[sample_width-1:0];
				end
			end
			strobe: begin
				// filter output or loopback, per channel
				left_out <= left_filter_en ? left_filtered : left_in;
				right_out <= right_filter_en ? right_filtered : right_in;
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== audio_dsp.sv ====
`timescale 1ns/1ps

module audio_dsp
	import audio_dsp_pkg::*;
(
	input  logic                 CLOCK_50,
	input  logic                 reset,
	input  logic                 left_filter_en,
	input  logic                 right_filter_en,
	input  logic                 bus_ack,
	input  logic [bus_width-1:0] bus_read_data,
	output logic [bus_width-1:0] bus_addr,
	output logic [bus_width-1:0] bus_write_data,
	output logic                 bus_read,
	output logic                 bus_write
);

	// 48 kHz sample strobe from the bus side
	logic sample_ready;
	logic signed [sample_width-1:0] left_in, right_in;
	logic signed [sample_width-1:0] left_filtered, right_filtered;

	audio_bus_master master_i (
		.CLOCK_50(CLOCK_50), .reset(reset),
		.left_filter_en(left_filter_en), .right_filter_en(right_filter_en),
		.left_filtered(left_filtered), .right_filtered(right_filtered),
		.bus_ack(bus_ack), .bus_read_data(bus_read_data),
		.bus_addr(bus_addr), .bus_write_data(bus_write_data),
		.bus_read(bus_read), .bus_write(bus_write),
		.sample_ready(sample_ready), .left_in(left_in), .right_in(right_in)
	);

	// right channel, band-pass at full rate
	biquad_filter #(
		.b1(bp300_48k_b1), .b2(bp300_48k_b2), .b3(bp300_48k_b3),
		.a2(bp300_48k_a2), .a3(bp300_48k_a3)
	) right_filter_i (
		.CLOCK_50(CLOCK_50), .reset(reset), .sample_ready(sample_ready),
		.audio_in(right_in), .audio_out(right_filtered)
	);

	// left channel, decimated band-pass
	decimation_chain left_chain_i (
		.CLOCK_50(CLOCK_50), .reset(reset), .sample_ready(sample_ready),
		.audio_in(left_in), .audio_out(left_filtered)
	);

endmodule

// ==== audio_dsp_props.sv ====
`timescale 1ns/1ps

module audio_dsp_props (
	input logic CLOCK_50,
	input logic reset,
	input logic bus_read,
	input logic bus_write,
	input logic bus_ack,
	input logic sample_ready
);

	// one request kind at a time
	no_overlap: assert property (@(posedge CLOCK_50) disable iff (reset)
		!(bus_read && bus_write))
		else $error("bus_read and bus_write high together");

	// request held until the slave acks
	read_held: assert property (@(posedge CLOCK_50) disable iff (reset)
		(bus_read && !bus_ack) |=> bus_read)
		else $error("bus_read dropped before bus_ack");

	write_held: assert property (@(posedge CLOCK_50) disable iff (reset)
		(bus_write && !bus_ack) |=> bus_write)
		else $error("bus_write dropped before bus_ack");

	// sample strobe is a single cycle
	strobe_pulse: assert property (@(posedge CLOCK_50) disable iff (reset)
		sample_ready |=> !sample_ready)
		else $error("sample_ready longer than one cycle");

endmodule

bind audio_dsp audio_dsp_props props_i (
	.CLOCK_50(CLOCK_50), .reset(reset), .bus_read(bus_read), .bus_write(bus_write),
	.bus_ack(bus_ack), .sample_ready(sample_ready)
);

// ==== audio_codec_model.sv ====
`timescale 1ns/1ps

module audio_codec_model
	import audio_dsp_pkg::*;
(
	input  logic                   CLOCK_50,
	input  logic                   reset,
	input  logic [bus_width-1:0]   bus_addr,
	input  logic [bus_width-1:0]   bus_write_data,
	input  logic                   bus_read,
	input  logic                   bus_write,
	output logic                   bus_ack,
	output logic [bus_width-1:0]   bus_read_data,
	input  logic [space_width-1:0] write_space,
	input  logic [space_width-1:0] read_count,
	input  logic [sample_width-1:0] left_sample,
	input  logic [sample_width-1:0] right_sample,
	output logic [31:0]            data_reads,
	output logic [31:0]            pair_count,
	output logic [sample_width-1:0] captured_left,
	output logic [sample_width-1:0] captured_right,
	output logic                   bad_access
);

	// ack delay of 1 to 4 cycles, two lfsr bits per request
	logic [15:0] lfsr, lfsr_next1, lfsr_next2;
	logic [1:0] draw;
	logic [2:0] wait_cnt;
	logic busy;
	// left word written, right word still owed
	logic left_seen;

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	assign lfsr_next1 = lfsr_step(lfsr);
	assign lfsr_next2 = lfsr_step(lfsr_next1);
	assign draw = {lfsr_next1[0], lfsr[0]};

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			bus_ack <= 1'b0;
			bus_read_data <= '0;
			busy <= 1'b0;
			wait_cnt <= '0;
			lfsr <= 16'd3686;
			data_reads <= '0;
			pair_count <= '0;
			captured_left <= '0;
			captured_right <= '0;
			left_seen <= 1'b0;
			bad_access <= 1'b0;
		end else if (bus_ack) begin
			// request drops on this edge
			bus_ack <= 1'b0;
			busy <= 1'b0;
		end else if (busy) begin
			if (wait_cnt > 3'd1) begin
				wait_cnt <= wait_cnt - 3'd1;
			end else begin
				bus_ack <= 1'b1;
				if (bus_read) begin
					if (bus_addr == fifo_status_addr) begin
						bus_read_data <= {write_space, 16'h0000, read_count};
					end else if (bus_addr == left_data_addr) begin
						bus_read_data <= {16'h0000, left_sample};
						data_reads <= data_reads + 32'd1;
					end else if (bus_addr == right_data_addr) begin
						bus_read_data <= {16'h0000, right_sample};
						data_reads <= data_reads + 32'd1;
					end else begin
						bad_access <= 1'b1;
					end
				end else begin
					// upper half of written data must be zero
					if (bus_write_data[31:16] != 16'h0000) begin
						bad_access <= 1'b1;
					end
					if (bus_addr == left_data_addr && !left_seen) begin
						captured_left <= bus_write_data[15:0];
						left_seen <= 1'b1;
					end else if (bus_addr == right_data_addr && left_seen) begin
						captured_right <= bus_write_data[15:0];
						left_seen <= 1'b0;
						pair_count <= pair_count + 32'd1;
					end else begin
						bad_access <= 1'b1;
					end
				end
			end
		end else if (bus_read || bus_write) begin
			busy <= 1'b1;
			wait_cnt <= 3'd1 + {1'b0, draw};
			lfsr <= lfsr_next2;
		end
	end

endmodule

// ==== audio_dsp_tb.sv ====
`timescale 1ns/1ps

module audio_dsp_tb
	import audio_dsp_pkg::*;
();

	localparam int reset_cycles = 16;
	localparam int cycles_per_line = 200;
	localparam int max_lines = 64;
	localparam int hold_cycles = 40;

	logic CLOCK_50 = 1'b0;
	logic reset, left_filter_en, right_filter_en;
	logic bus_ack, bus_read, bus_write;
	logic [bus_width-1:0] bus_read_data, bus_addr, bus_write_data;

	// codec model controls and observations
	logic [space_width-1:0] write_space, read_count;
	logic [sample_width-1:0] left_sample, right_sample;
	logic [31:0] data_reads, pair_count;
	logic [sample_width-1:0] captured_left, captured_right;
	logic bad_access;

	logic [31:0] vec_mem [0:8*max_lines-1];
	int cycle_count = 0;
	int cycle_limit = reset_cycles + cycles_per_line * max_lines;
	int pairs_seen = 0;

	// pairs seen on the bus and pairs owed by the model
	logic [15:0] written_left_q[$], written_right_q[$];
	logic [15:0] exp_left_q[$], exp_right_q[$];

	//////////////////////////////////////////////////////////////////////
	// reference model state
	// filters 0 to 3 are right bp, lp1, lp2 and the decimated bp

	logic signed [17:0] coef [4][5];
	logic signed [17:0] hx1 [4], hx2 [4], hy1 [4], hy2 [4];
	logic signed [17:0] r_mac, s1_mac, s2_mac, s3_mac;
	logic signed [15:0] r_out, s1_out, s2_out, s3_out;
	int dec_count;

	audio_dsp dut_i (
		.CLOCK_50(CLOCK_50), .reset(reset),
		.left_filter_en(left_filter_en), .right_filter_en(right_filter_en),
		.bus_ack(bus_ack), .bus_read_data(bus_read_data),
		.bus_addr(bus_addr), .bus_write_data(bus_write_data),
		.bus_read(bus_read), .bus_write(bus_write)
	);

	audio_codec_model codec_i (
		.CLOCK_50(CLOCK_50), .reset(reset),
		.bus_addr(bus_addr), .bus_write_data(bus_write_data),
		.bus_read(bus_read), .bus_write(bus_write),
		.bus_ack(bus_ack), .bus_read_data(bus_read_data),
		.write_space(write_space), .read_count(read_count),
		.left_sample(left_sample), .right_sample(right_sample),
		.data_reads(data_reads), .pair_count(pair_count),
		.captured_left(captured_left), .captured_right(captured_right),
		.bad_access(bad_access)
	);

	always #10 CLOCK_50 = ~CLOCK_50;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			abort_run($sformatf("FAILED %s: expected 0x%08h, got 0x%08h",
				name, expected, actual));
		end
	endtask

	// watchdog
	always @(posedge CLOCK_50) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			abort_run("timeout, the run went past its cycle limit");
		end
	end

	// collect each finished pair from the codec
	always @(negedge CLOCK_50) begin
		if (pair_count != 32'(pairs_seen)) begin
			written_left_q.push_back(captured_left);
			written_right_q.push_back(captured_right);
			pairs_seen = pairs_seen + 1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// fixed point reference

	// 2.16 product keeps the sign and bits 32..16
	function automatic logic signed [17:0] scaled(input logic signed [17:0] c,
		input logic signed [17:0] v);
		logic signed [35:0] p;
		p = 36'(c) * 36'(v);
		return {p[35], p[32:16]};
	endfunction

	task automatic biquad_run(input int id, input logic signed [15:0] x,
		output logic signed [17:0] y);
		logic signed [17:0] xe;
		xe = {{2{x[15]}}, x};
		y = scaled(coef[id][0], xe) + scaled(coef[id][1], hx1[id])
			+ scaled(coef[id][2], hx2[id]) + scaled(coef[id][3], hy1[id])
			+ scaled(coef[id][4], hy2[id]);
		hx2[id] = hx1[id];
		hx1[id] = xe;
		hy2[id] = hy1[id];
		hy1[id] = y;
	endtask

	task automatic load_coefficients();
		coef[0] = '{bp300_48k_b1, bp300_48k_b2, bp300_48k_b3, bp300_48k_a2, bp300_48k_a3};
		coef[1] = '{dec_lp1_b1, dec_lp1_b2, dec_lp1_b3, dec_lp1_a2, dec_lp1_a3};
		coef[2] = '{dec_lp2_b1, dec_lp2_b2, dec_lp2_b3, dec_lp2_a2, dec_lp2_a3};
		coef[3] = '{bp300_8k_b1, bp300_8k_b2, bp300_8k_b3, bp300_8k_a2, bp300_8k_a3};
		for (int i = 0; i < 4; i++) begin
			hx1[i] = '0;
			hx2[i] = '0;
			hy1[i] = '0;
			hy2[i] = '0;
		end
		r_mac = '0;
		s1_mac = '0;
		s2_mac = '0;
		s3_mac = '0;
		r_out = '0;
		s1_out = '0;
		s2_out = '0;
		s3_out = '0;
		dec_count = 0;
	endtask

	// one strobe returns the filter outputs latched in that cycle
	task automatic model_sample(input logic signed [15:0] l, input logic signed [15:0] r,
		output logic [15:0] exp_l, output logic [15:0] exp_r);
		logic dec;
		logic signed [15:0] s3_in;
		exp_l = s3_out;
		exp_r = r_out;
		dec = (dec_count == int'(decimation_ratio) - 1);
		// outputs take the sums of the previous strobe
		r_out = r_mac[15:0];
		s1_out = s1_mac[15:0];
		s2_out = s2_mac[15:0];
		if (dec) begin
			s3_out = s3_mac[15:0];
		end
		biquad_run(0, r, r_mac);
		biquad_run(1, l, s1_mac);
		biquad_run(2, s1_out, s2_mac);
		if (dec) begin
			// gain of two into the 8 kHz band-pass
			s3_in = {s2_out[14:0], 1'b0};
			biquad_run(3, s3_in, s3_mac);
			dec_count = 0;
		end else begin
			dec_count = dec_count + 1;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		int line_count;
		int reads_before;
		int pairs_before;
		int total_pairs;
		logic [31:0] col [8];
		logic [15:0] model_l, model_r, want_l, want_r;
		reset = 1'b1;
		left_filter_en = 1'b0;
		right_filter_en = 1'b0;
		write_space = '0;
		read_count = '0;
		left_sample = '0;
		right_sample = '0;
		total_pairs = 0;
		load_coefficients();
		for (int i = 0; i < 8 * max_lines; i++) begin
			vec_mem[i] = 32'hbad0_0000 ^ 32'(i);
		end
		$readmemh("audio_dsp_vectors.txt", vec_mem);
		line_count = 0;
		while (line_count < max_lines && vec_mem[8*line_count] <= 32'd1) begin
			line_count = line_count + 1;
		end
		if (line_count == 0) begin
			abort_run("the vector file holds no usable lines");
		end
		cycle_limit = reset_cycles + cycles_per_line * line_count;

		repeat (reset_cycles) @(negedge CLOCK_50);
		compare_value("bus_read", 32'd0, 32'(bus_read));
		compare_value("bus_write", 32'd0, 32'(bus_write));
		reset = 1'b0;

		// first request is the status poll
		while (!bus_read && !bus_write) @(negedge CLOCK_50);
		compare_value("bus_write", 32'd0, 32'(bus_write));
		compare_value("bus_addr", fifo_status_addr, bus_addr);

		for (int line = 0; line < line_count; line++) begin
			for (int j = 0; j < 8; j++) begin
				col[j] = vec_mem[8*line+j];
			end
			left_filter_en = col[0][0];
			right_filter_en = col[1][0];
			write_space = col[2][7:0];
			read_count = col[3][7:0];
			left_sample = col[4][15:0];
			right_sample = col[5][15:0];
			reads_before = int'(data_reads);
			if (read_count != '0) begin
				// one pair per line and then close the fifo again
				while (int'(data_reads) < reads_before + 2) @(negedge CLOCK_50);
				read_count = '0;
				model_sample(left_sample, right_sample, model_l, model_r);
				if (col[6] == 32'hffff_ffff) begin
					want_l = left_filter_en ? model_l : left_sample;
				end else begin
					want_l = col[6][15:0];
				end
				if (col[7] == 32'hffff_ffff) begin
					want_r = right_filter_en ? model_r : right_sample;
				end else begin
					want_r = col[7][15:0];
				end
				exp_left_q.push_back(want_l);
				exp_right_q.push_back(want_r);
				total_pairs = total_pairs + 1;
			end else begin
				repeat (hold_cycles) @(negedge CLOCK_50);
				compare_value("data_reads", 32'(reads_before), data_reads);
			end
			if (write_space > write_space_min) begin
				while (written_left_q.size() < exp_left_q.size()) @(negedge CLOCK_50);
				while (exp_left_q.size() > 0) begin
					compare_value("left write data", 32'(exp_left_q.pop_front()),
						32'(written_left_q.pop_front()));
					compare_value("right write data", 32'(exp_right_q.pop_front()),
						32'(written_right_q.pop_front()));
				end
			end else begin
				// nothing may be written without space
				pairs_before = pairs_seen;
				repeat (hold_cycles) @(negedge CLOCK_50);
				compare_value("pair_count", 32'(pairs_before), 32'(pairs_seen));
			end
			if (bad_access) begin
				abort_run("the codec saw an access at a wrong address or out of order");
			end
		end

		// every pair goes out exactly once
		repeat (hold_cycles) @(negedge CLOCK_50);
		compare_value("pair_count", 32'(total_pairs), 32'(pairs_seen));
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== audio_dsp_vectors.txt ====
// left_en right_en write_space read_count left_in right_in exp_left exp_right
// ffffffff in an expected column: loopback or reference model value
0 0 10 1 0100 ff00 00000100 0000ff00
0 0 10 1 0800 f800 00000800 0000f800
0 1 10 1 1000 2000 00001000 ffffffff
0 1 10 1 e000 3000 0000e000 ffffffff
0 1 02 1 2000 c000 00002000 ffffffff
0 1 10 1 3000 5000 00003000 ffffffff
0 0 10 0 0000 0000 00000000 00000000
1 1 10 1 4000 6000 ffffffff ffffffff
1 1 10 1 c000 a000 ffffffff ffffffff
1 1 10 1 2800 1800 ffffffff ffffffff
1 0 10 1 d800 7000 ffffffff ffffffff
1 1 10 1 5000 9000 ffffffff ffffffff
1 1 10 1 b000 4000 ffffffff ffffffff
1 1 01 0 0000 0000 00000000 00000000
1 1 10 1 3800 c800 ffffffff ffffffff
0 1 10 1 f000 2400 ffffffff ffffffff
1 1 10 1 6000 e000 ffffffff ffffffff
1 1 10 1 a800 5800 ffffffff ffffffff
1 1 10 1 1c00 b800 ffffffff ffffffff
1 1 10 1 e400 3c00 ffffffff ffffffff
1 1 10 1 4400 8800 ffffffff ffffffff

// ==== audio_dsp.f ====
audio_dsp_pkg.sv
biquad_filter.sv
decimation_chain.sv
audio_bus_master.sv
audio_dsp.sv
audio_dsp_props.sv
audio_codec_model.sv
audio_dsp_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the audio_dsp testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module audio_dsp_tb \
	-f audio_dsp.f -o audio_dsp_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "compile failed, see build.log"
	exit 1
fi

./obj_dir/audio_dsp_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation returned an error status, see sim.log"
	exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1
